// File: hdl/dram_pkg.sv
package dram_pkg;

  // Requester side
  localparam int addr_width   = 27;  // Byte address, shared with the app interface
  localparam int word_width   = 64;
  localparam int strb_width   = 8;   // One strobe per byte of a word

  // App interface side
  localparam int line_width   = 128;
  localparam int mask_width   = 16;  // A set bit leaves that byte untouched
  localparam int half_sel_bit = 3;   // Picks the upper word of a line

  localparam int cmd_width = 3;
  localparam logic [cmd_width-1:0] cmd_write = 3'd0;
  localparam logic [cmd_width-1:0] cmd_read  = 3'd1;

  // Behavioral model of the memory controller
  localparam int model_lines  = 64;  // Indexed by address bits 9 to 4
  localparam int read_latency = 4;   // Accepted read command to data valid
  localparam int calib_cycles = 16;  // Reset release to calibration done

endpackage

// File: hdl/app_lane_map.sv
module app_lane_map (
  input  logic                            half_sel,
  input  logic [dram_pkg::word_width-1:0] word,
  input  logic [dram_pkg::strb_width-1:0] strb,
  input  logic [dram_pkg::line_width-1:0] rd_line,
  output logic [dram_pkg::line_width-1:0] wr_line,
  output logic [dram_pkg::mask_width-1:0] wr_mask,
  output logic [dram_pkg::word_width-1:0] rd_word
);
  import dram_pkg::*;

  assign wr_line = {word, word};  // The mask decides which copy lands

  always_comb begin
    wr_mask = '1;
    if (half_sel) begin
      wr_mask[mask_width-1 -: strb_width] = ~strb;
    end else begin
      wr_mask[strb_width-1:0] = ~strb;
    end
  end

  assign rd_word = half_sel ? rd_line[line_width-1 -: word_width] : rd_line[word_width-1:0];

endmodule

// File: hdl/dram_app_ctrl.sv
module dram_app_ctrl (
  input  logic                            mem_ui_clk,
  input  logic                            mem_ui_rst,
  input  logic                            calib_complete,
  input  logic                            mem_valid,
  input  logic                            mem_we,
  input  logic [dram_pkg::addr_width-1:0] mem_addr,
  input  logic [dram_pkg::word_width-1:0] mem_wdata,
  input  logic [dram_pkg::strb_width-1:0] mem_wstrb,
  input  logic                            app_rdy,
  input  logic                            app_wdf_rdy,
  input  logic [dram_pkg::line_width-1:0] app_rd_data,
  input  logic                            app_rd_data_valid,
  input  logic                            app_rd_data_end,
  output logic                            mem_ready,
  output logic [dram_pkg::word_width-1:0] mem_rdata,
  output logic [dram_pkg::addr_width-1:0] app_addr,
  output logic [dram_pkg::cmd_width-1:0]  app_cmd,
  output logic                            app_en,
  output logic                            app_wdf_wren,
  output logic                            app_wdf_end,
  output logic [dram_pkg::line_width-1:0] app_wdf_data,
  output logic [dram_pkg::mask_width-1:0] app_wdf_mask
);
  import dram_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_capture,
    st_send_data,
    st_write_cmd,
    st_read_cmd,
    st_read_wait,
    st_respond,
    st_recover
  } state_t;

  state_t                state;
  state_t                state_next;
  logic                  req_half;
  logic [line_width-1:0] place_line;
  logic [mask_width-1:0] place_mask;
  logic [word_width-1:0] rd_word;
  logic                  rd_done;

  // Placement works on the held request fields so it can be registered in capture
  app_lane_map u_place (
    .half_sel (mem_addr[half_sel_bit]),
    .word     (mem_wdata),
    .strb     (mem_wstrb),
    .rd_line  ('0),
    .wr_line  (place_line),
    .wr_mask  (place_mask),
    .rd_word  ()
  );

  app_lane_map u_select (
    .half_sel (req_half),
    .word     ('0),
    .strb     ('0),
    .rd_line  (app_rd_data),
    .wr_line  (),
    .wr_mask  (),
    .rd_word  (rd_word)
  );

  assign rd_done = (state == st_read_wait) && app_rd_data_valid && app_rd_data_end;

  always_ff @(posedge mem_ui_clk) begin
    if (mem_ui_rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle:      if (mem_valid && calib_complete) state_next = st_capture;
      st_capture:   state_next = mem_we ? st_send_data : st_read_cmd;
      st_send_data: if (app_wdf_rdy) state_next = st_write_cmd;  // Data goes ahead of the command
      st_write_cmd: if (app_rdy) state_next = st_respond;
      st_read_cmd:  if (app_rdy) state_next = st_read_wait;
      st_read_wait: if (rd_done) state_next = st_respond;
      st_respond:   state_next = st_recover;
      st_recover:   state_next = st_idle;  // Requester drops mem_valid here
      default:      state_next = st_idle;
    endcase
  end

  always_comb begin
    app_en       = 1'b0;
    app_cmd      = cmd_write;
    app_wdf_wren = 1'b0;
    app_wdf_end  = 1'b0;
    case (state)
      st_send_data: begin
        app_wdf_wren = 1'b1;
        app_wdf_end  = 1'b1;  // Single beat per line
      end
      st_write_cmd: app_en = 1'b1;
      st_read_cmd: begin
        app_en  = 1'b1;
        app_cmd = cmd_read;
      end
      default: ;
    endcase
  end

  always_ff @(posedge mem_ui_clk) begin
    if (state == st_capture) begin
      req_half     <= mem_addr[half_sel_bit];
      app_addr     <= {mem_addr[addr_width-1:4], 4'h0};  // Line aligned
      app_wdf_data <= place_line;
      app_wdf_mask <= place_mask;
    end
  end

  always_ff @(posedge mem_ui_clk) begin
    if (mem_ui_rst) begin
      mem_ready <= 1'b0;
      mem_rdata <= '0;
    end else begin
      mem_ready <= (state == st_write_cmd && app_rdy) || rd_done;
      mem_rdata <= rd_done ? rd_word : '0;  // Zero outside a read response
    end
  end

endmodule

// File: hdl/app_mem_model.sv
module app_mem_model (
  input  logic                            mem_ui_clk,
  input  logic                            mem_ui_rst,
  input  logic                            app_en,
  input  logic [dram_pkg::cmd_width-1:0]  app_cmd,
  input  logic [dram_pkg::addr_width-1:0] app_addr,
  input  logic                            app_wdf_wren,
  input  logic                            app_wdf_end,
  input  logic [dram_pkg::line_width-1:0] app_wdf_data,
  input  logic [dram_pkg::mask_width-1:0] app_wdf_mask,
  output logic                            app_rdy,
  output logic                            app_wdf_rdy,
  output logic                            calib_complete,
  output logic [dram_pkg::line_width-1:0] app_rd_data,
  output logic                            app_rd_data_valid,
  output logic                            app_rd_data_end
);
  import dram_pkg::*;

  localparam int idx_width   = $clog2(model_lines);
  localparam int calib_width = $clog2(calib_cycles);

  logic [calib_width-1:0] calib_cnt;
  logic [1:0]             stall_cnt;
  logic                   cmd_acc;
  logic [idx_width-1:0]   line_idx;
  logic [line_width-1:0]  wdata_q;
  logic [mask_width-1:0]  wmask_q;
  logic [line_width-1:0]  lines [model_lines];
  logic [read_latency-1:0] rd_vld;
  logic [idx_width-1:0]   rd_idx [read_latency];

  always_ff @(posedge mem_ui_clk) begin
    if (mem_ui_rst) begin
      calib_cnt      <= '0;
      calib_complete <= 1'b0;
    end else if (!calib_complete) begin
      calib_cnt <= calib_cnt + 1'b1;
      if (calib_cnt == calib_width'(calib_cycles - 1)) calib_complete <= 1'b1;
    end
  end

  always_ff @(posedge mem_ui_clk) begin
    if (mem_ui_rst) begin
      stall_cnt <= '0;
    end else begin
      stall_cnt <= stall_cnt + 1'b1;
    end
  end

  // The two ready stalls land on different phases of the counter
  assign app_rdy     = calib_complete && (stall_cnt != 2'd3);
  assign app_wdf_rdy = calib_complete && (stall_cnt != 2'd1);

  assign cmd_acc  = app_en && app_rdy;
  assign line_idx = app_addr[idx_width+3:4];

  always_ff @(posedge mem_ui_clk) begin
    if (app_wdf_wren && app_wdf_end && app_wdf_rdy) begin
      wdata_q <= app_wdf_data;
      wmask_q <= app_wdf_mask;
    end
  end

  always_ff @(posedge mem_ui_clk) begin
    if (mem_ui_rst) begin
      for (int i = 0; i < model_lines; i++) begin
        lines[i] <= '0;
      end
    end else if (cmd_acc && app_cmd == cmd_write) begin
      for (int b = 0; b < mask_width; b++) begin
        if (!wmask_q[b]) lines[line_idx][b*8 +: 8] <= wdata_q[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge mem_ui_clk) begin
    if (mem_ui_rst) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= {rd_vld[read_latency-2:0], cmd_acc && app_cmd == cmd_read};
    end
  end

  always_ff @(posedge mem_ui_clk) begin
    rd_idx[0] <= line_idx;
    for (int i = 1; i < read_latency; i++) begin
      rd_idx[i] <= rd_idx[i-1];
    end
  end

  // Last stage of the pipe is the response cycle
  assign app_rd_data_valid = rd_vld[read_latency-1];
  assign app_rd_data_end   = rd_vld[read_latency-1];
  assign app_rd_data       = lines[rd_idx[read_latency-1]];

endmodule

// File: hdl/dram_subsys.sv
module dram_subsys (
  input  logic                            mem_ui_clk,
  input  logic                            mem_ui_rst,
  input  logic                            mem_valid,
  input  logic                            mem_we,
  input  logic [dram_pkg::addr_width-1:0] mem_addr,
  input  logic [dram_pkg::word_width-1:0] mem_wdata,
  input  logic [dram_pkg::strb_width-1:0] mem_wstrb,
  output logic                            mem_ready,
  output logic [dram_pkg::word_width-1:0] mem_rdata,
  output logic                            calib_complete
);
  import dram_pkg::*;

  logic [addr_width-1:0] app_addr;
  logic [cmd_width-1:0]  app_cmd;
  logic                  app_en;
  logic                  app_rdy;
  logic                  app_wdf_wren;
  logic                  app_wdf_end;
  logic                  app_wdf_rdy;
  logic [line_width-1:0] app_wdf_data;
  logic [mask_width-1:0] app_wdf_mask;
  logic [line_width-1:0] app_rd_data;
  logic                  app_rd_data_valid;
  logic                  app_rd_data_end;

  dram_app_ctrl u_ctrl (
    .mem_ui_clk        (mem_ui_clk),
    .mem_ui_rst        (mem_ui_rst),
    .calib_complete    (calib_complete),
    .mem_valid         (mem_valid),
    .mem_we            (mem_we),
    .mem_addr          (mem_addr),
    .mem_wdata         (mem_wdata),
    .mem_wstrb         (mem_wstrb),
    .app_rdy           (app_rdy),
    .app_wdf_rdy       (app_wdf_rdy),
    .app_rd_data       (app_rd_data),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data_end   (app_rd_data_end),
    .mem_ready         (mem_ready),
    .mem_rdata         (mem_rdata),
    .app_addr          (app_addr),
    .app_cmd           (app_cmd),
    .app_en            (app_en),
    .app_wdf_wren      (app_wdf_wren),
    .app_wdf_end       (app_wdf_end),
    .app_wdf_data      (app_wdf_data),
    .app_wdf_mask      (app_wdf_mask)
  );

  // Stands in for the vendor controller and the DDR2 device
  app_mem_model u_model (
    .mem_ui_clk        (mem_ui_clk),
    .mem_ui_rst        (mem_ui_rst),
    .app_en            (app_en),
    .app_cmd           (app_cmd),
    .app_addr          (app_addr),
    .app_wdf_wren      (app_wdf_wren),
    .app_wdf_end       (app_wdf_end),
    .app_wdf_data      (app_wdf_data),
    .app_wdf_mask      (app_wdf_mask),
    .app_rdy           (app_rdy),
    .app_wdf_rdy       (app_wdf_rdy),
    .calib_complete    (calib_complete),
    .app_rd_data       (app_rd_data),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data_end   (app_rd_data_end)
  );

endmodule

// File: bench/tb_dram_subsys.sv
module tb_dram_subsys;
  timeunit 1ns;
  timeprecision 1ps;
  import dram_pkg::*;

  typedef struct packed {
    logic                  we;
    logic [addr_width-1:0] addr;
    logic [word_width-1:0] wdata;
    logic [strb_width-1:0] strb;
    logic [word_width-1:0] exp;  // Read data the entry expects, zero for writes
  } entry_t;

  localparam int          n_tests     = 18;
  localparam logic [31:0] lfsr_seed   = 32'hb46d_56a0;
  localparam int          cycle_limit = calib_cycles + 5 + n_tests * (30 + 3);

  // Entry 0 goes out at reset release, before calibration is done
  localparam entry_t test_table [n_tests] = '{
    '{1'b1, 27'h000, 64'h1122_3344_5566_7788, 8'hff, 64'h0},
    '{1'b0, 27'h000, 64'h0, 8'h00, 64'h1122_3344_5566_7788},
    '{1'b1, 27'h040, 64'hdead_beef_cafe_f00d, 8'hff, 64'h0},
    '{1'b1, 27'h040, 64'h0102_0304_0506_0708, 8'h0f, 64'h0},
    '{1'b0, 27'h040, 64'h0, 8'h00, 64'hdead_beef_0506_0708},
    '{1'b1, 27'h048, 64'ha5a5_5a5a_0f0f_f0f0, 8'hff, 64'h0},
    '{1'b0, 27'h040, 64'h0, 8'h00, 64'hdead_beef_0506_0708},
    '{1'b0, 27'h048, 64'h0, 8'h00, 64'ha5a5_5a5a_0f0f_f0f0},
    '{1'b0, 27'h3f8, 64'h0, 8'h00, 64'h0},
    '{1'b1, 27'h048, 64'h1111_2222_3333_4444, 8'hc3, 64'h0},
    '{1'b0, 27'h048, 64'h0, 8'h00, 64'h1111_5a5a_0f0f_4444},
    '{1'b1, 27'h208, 64'h0123_4567_89ab_cdef, 8'hff, 64'h0},
    '{1'b0, 27'h208, 64'h0, 8'h00, 64'h0123_4567_89ab_cdef},
    '{1'b0, 27'h200, 64'h0, 8'h00, 64'h0},
    '{1'b1, 27'h100, 64'hffff_0000_ffff_0000, 8'h3c, 64'h0},
    '{1'b0, 27'h100, 64'h0, 8'h00, 64'h0000_0000_ffff_0000},
    '{1'b0, 27'h000, 64'h0, 8'h00, 64'h1122_3344_5566_7788},
    '{1'b0, 27'h008, 64'h0, 8'h00, 64'h0}
  };

  logic                  mem_ui_clk = 1'b0;
  logic                  mem_ui_rst;
  logic                  mem_valid;
  logic                  mem_we;
  logic [addr_width-1:0] mem_addr;
  logic [word_width-1:0] mem_wdata;
  logic [strb_width-1:0] mem_wstrb;
  logic                  mem_ready;
  logic [word_width-1:0] mem_rdata;
  logic                  calib_complete;

  logic [31:0]           lfsr_state = lfsr_seed;
  logic [word_width-1:0] shadow [logic [addr_width-4:0]];  // Keyed by word address
  int                    pass_count  = 0;
  int                    fail_count  = 0;
  int                    req_count   = 0;
  int                    ready_count = 0;
  int                    calib_count = 0;
  logic                  calib_seen  = 1'b0;

  dram_subsys UUT (
    .mem_ui_clk     (mem_ui_clk),
    .mem_ui_rst     (mem_ui_rst),
    .mem_valid      (mem_valid),
    .mem_we         (mem_we),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .mem_wstrb      (mem_wstrb),
    .mem_ready      (mem_ready),
    .mem_rdata      (mem_rdata),
    .calib_complete (calib_complete)
  );

  always #10 mem_ui_clk = ~mem_ui_clk;

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_gap(output int gap);
    gap = 0;
    repeat (2) begin
      lfsr_state = lfsr_step(lfsr_state);
      gap = (gap << 1) | lfsr_state[0];
    end
  endtask

  function automatic logic [word_width-1:0] merge_bytes(
    input logic [word_width-1:0] old_word,
    input logic [word_width-1:0] new_word,
    input logic [strb_width-1:0] strb
  );
    logic [word_width-1:0] res;
    res = old_word;
    for (int b = 0; b < strb_width; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  // Holds the request until mem_ready, then drops it for at least one cycle
  task automatic run_request(input entry_t e, output logic [word_width-1:0] rdata);
    mem_valid = 1'b1;
    mem_we    = e.we;
    mem_addr  = e.addr;
    mem_wdata = e.wdata;
    mem_wstrb = e.strb;
    req_count++;
    do begin
      @(posedge mem_ui_clk);
      #1;
    end while (!mem_ready);
    rdata = mem_rdata;
    @(posedge mem_ui_clk);
    #2;
    mem_valid = 1'b0;
    @(posedge mem_ui_clk);
    #2;
  endtask

  always @(posedge mem_ui_clk) begin
    #1;
    if (!mem_ui_rst && !calib_seen) begin
      calib_count++;  // Edges since reset release
      if (calib_complete) begin
        calib_seen = 1'b1;
        if (calib_count != calib_cycles) begin
          $display("[FAIL] %0t calib_complete expected %0d got %0d cycles", $time,
                   calib_cycles, calib_count);
          fail_count++;
        end else begin
          $display("[ok] calib_complete after %0d cycles", calib_count);
          pass_count++;
        end
      end
    end
  end

  always @(posedge mem_ui_clk) begin
    #1;
    if (mem_ready) begin
      ready_count++;
      if (!calib_complete) begin
        $display("mem_ready came before calibration finished at %0t", $time);
        fail_count++;
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge mem_ui_clk);
      cycles++;
    end
    $display("Timed out after %0d cycles with requests still open", cycles);
    $display("Test failures found");
    $finish;
  end

  initial begin
    entry_t                e;
    logic [word_width-1:0] got;
    logic [word_width-1:0] model;
    logic [addr_width-4:0] widx;
    int                    gap;
    mem_ui_rst = 1'b1;
    mem_valid  = 1'b0;
    mem_we     = 1'b0;
    mem_addr   = '0;
    mem_wdata  = '0;
    mem_wstrb  = '0;
    repeat (5) @(posedge mem_ui_clk);
    #2;
    mem_ui_rst = 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      e     = test_table[i];
      widx  = e.addr[addr_width-1:3];
      model = shadow.exists(widx) ? shadow[widx] : '0;
      run_request(e, got);
      if (e.we) begin
        shadow[widx] = merge_bytes(model, e.wdata, e.strb);
        if (got !== '0) begin
          $display("[FAIL] %0t mem_rdata expected %h got %h", $time, 64'h0, got);
          fail_count++;
        end else begin
          $display("[ok] test %0d write %h strobe %h to %h", i, e.wdata, e.strb, e.addr);
          pass_count++;
        end
      end else if (model !== e.exp) begin
        $display("Test %0d table expects %h at %h but the shadow memory holds %h", i,
                 e.exp, e.addr, model);
        fail_count++;
      end else if (got !== e.exp) begin
        $display("[FAIL] %0t mem_rdata expected %h got %h", $time, e.exp, got);
        fail_count++;
      end else begin
        $display("[ok] test %0d read %h from %h", i, got, e.addr);
        pass_count++;
      end
      next_gap(gap);
      repeat (gap) begin
        @(posedge mem_ui_clk);
        #2;
      end
    end
    if (ready_count != req_count) begin
      $display("%0d requests drew %0d mem_ready pulses", req_count, ready_count);
      fail_count++;
    end
    $display("%0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: src.f
hdl/dram_pkg.sv
hdl/app_lane_map.sv
hdl/dram_app_ctrl.sv
hdl/app_mem_model.sv
hdl/dram_subsys.sv
bench/tb_dram_subsys.sv

// File: Bender.yml
package:
  name: dram_subsys

sources:
  - hdl/dram_pkg.sv
  - hdl/app_lane_map.sv
  - hdl/dram_app_ctrl.sv
  - hdl/app_mem_model.sv
  - hdl/dram_subsys.sv
  - target: test
    files:
      - bench/tb_dram_subsys.sv
